/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none
// testbench clock and reset: 40 ns clock, active low reset held for the first 10 cycles
module tb_clock (
  output logic CLK,
  output logic RST
);

  localparam int HALF_NS     = 20;
  localparam int RST_CYCLES  = 10;

  initial
  begin
    CLK = 1'b0;
    forever #HALF_NS CLK = ~CLK;
  end

  initial
  begin
    RST = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    RST <= 1'b1;  // release on an edge like any other input
  end

endmodule

`default_nettype wire

/* dv/tb_l1_snoop_cache.sv */
`timescale 1ns/1ps
`default_nettype none
// L1 snoop cache testbench driving random processor and snoop traffic against a MESI model
module tb_l1_snoop_cache;

  localparam logic [31:0] SEED        = 32'hbbc8_a34e;
  localparam int          N_TXN       = 400;
  localparam int          CYC_PER_TXN = 200;

  logic CLK;
  logic RST;
  logic cpu_req, cpu_we, cpu_ack, mem_req, mem_ack, mem_shared;
  logic snoop_req, snoop_rdx, snoop_ack, snoop_hit, snoop_dirty;
  logic [7:0] cpu_wdata, cpu_rdata;
  logic [cache_pkg::ADDR_W-1:0] cpu_addr, mem_addr, snoop_addr;
  logic [cache_pkg::LINE_W-1:0] mem_wdata, mem_rdata, snoop_data;
  cache_pkg::bus_op_e mem_op;
  logic [cache_pkg::CNT_W-1:0] rd_hit_cnt, rd_miss_cnt, wr_hit_cnt, wr_miss_cnt;

  // reference model
  logic [7:0]                   ref_bytes [logic [15:0]];  // processor view of written bytes
  logic [cache_pkg::LINE_W-1:0] mem_lines [logic [15:0]];  // next level lines once changed
  logic [cache_pkg::TAG_W-1:0]  m_tag   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
  cache_pkg::mesi_e             m_state [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
  logic [cache_pkg::WAY_W-1:0]  m_rr    [cache_pkg::NUM_SETS];
  int n_wb = 0;
  int n_upgr = 0;
  int n_fill = 0;
  logic last_shared;
  cache_pkg::bus_op_e last_fill_op;
  logic [cache_pkg::CNT_W-1:0] exp_rd_hit, exp_rd_miss, exp_wr_hit, exp_wr_miss;

  tb_clock u_clk (.CLK, .RST);

  l1_snoop_cache u_dut (
    .CLK, .RST,
    .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_ack, .cpu_rdata,
    .mem_req, .mem_op, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata, .mem_shared,
    .snoop_req, .snoop_rdx, .snoop_addr, .snoop_ack, .snoop_hit, .snoop_dirty, .snoop_data,
    .rd_hit_cnt, .rd_miss_cnt, .wr_hit_cnt, .wr_miss_cnt
  );

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  // memory power-up pattern of each byte
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[7:0] ^ (a[15:8] * 8'd7 + 8'd61);
  endfunction

  function automatic logic [7:0] ref_byte(input logic [15:0] a);
    if (ref_bytes.exists(a))
      return ref_bytes[a];
    else
      return fill_byte(a);
  endfunction

  function automatic logic [127:0] model_line(input logic [15:0] a);
    logic [127:0] l;
    for (int o = 0; o < 16; o++)
      l[o*8 +: 8] = ref_byte({a[15:4], 4'(o)});
    return l;
  endfunction

  function automatic logic [127:0] mem_line(input logic [15:0] la);
    logic [127:0] l;
    if (mem_lines.exists(la))
      l = mem_lines[la];
    else
      for (int o = 0; o < 16; o++)
        l[o*8 +: 8] = fill_byte({la[15:4], 4'(o)});
    return l;
  endfunction

  // valid way holding the tag or -1
  function automatic int find_way(input logic [3:0] idx, input logic [7:0] tag);
    int w;
    w = -1;
    for (int i = cache_pkg::NUM_WAYS - 1; i >= 0; i--)
      if (m_state[idx][i] != cache_pkg::ST_I && m_tag[idx][i] == tag)
        w = i;
    return w;
  endfunction

  function automatic int pick_victim(input logic [3:0] idx);
    int v;
    v = int'(m_rr[idx]);  // round robin unless some way is free
    for (int i = cache_pkg::NUM_WAYS - 1; i >= 0; i--)
      if (m_state[idx][i] == cache_pkg::ST_I)
        v = i;
    return v;
  endfunction

  // six tags on two sets overflow the four ways
  function automatic logic [15:0] pick_addr();
    logic [7:0] tag;
    logic [3:0] idx;
    tag = 8'h90 + 8'($urandom_range(5, 0));
    idx = ($urandom_range(1, 0) == 0) ? 4'h2 : 4'hb;
    return {tag, idx, 4'($urandom_range(15, 0))};
  endfunction

  task automatic check_writeback(input logic [15:0] la, input logic [127:0] data);
    int w;
    w = find_way(la[7:4], la[15:8]);
    assert (w >= 0 && m_state[la[7:4]][w] == cache_pkg::ST_M)
      else stop_with_fail($sformatf("** Error at %0t: write-back of %h, line not modified",
                                    $time, la));
    assert (data == model_line(la))
      else stop_with_fail($sformatf("** Error at %0t: write-back of %h carried %h, expected %h",
                                    $time, la, data, model_line(la)));
  endtask

  task automatic cpu_access(input logic we, input logic [15:0] addr, input logic [7:0] wdata);
    logic [3:0] idx;
    logic was_hit;
    logic vdirty;
    int w, v, cycles, wb0, upgr0, fill0;
    cache_pkg::mesi_e st0;
    idx = addr[7:4];
    w = find_way(idx, addr[15:8]);
    v = pick_victim(idx);
    was_hit = (w >= 0);
    st0 = cache_pkg::ST_I;
    if (was_hit)
      st0 = m_state[idx][w];
    vdirty = !was_hit && (m_state[idx][v] == cache_pkg::ST_M);
    wb0 = n_wb;
    upgr0 = n_upgr;
    fill0 = n_fill;
    @(posedge CLK);
    cpu_we    <= we;
    cpu_addr  <= addr;
    cpu_wdata <= wdata;
    cpu_req   <= 1'b1;
    cycles = 0;
    do
    begin
      @(negedge CLK);
      cycles++;
    end
    while (!cpu_ack);
    // req is sampled at the next edge and ack follows two edges later
    if (was_hit && (!we || st0 != cache_pkg::ST_S))
      assert (cycles == 4)
        else stop_with_fail($sformatf("** Error at %0t: hit on %h acked %0d cycles after req",
                                      $time, addr, cycles));
    if (!we)
      assert (cpu_rdata == ref_byte(addr))
        else stop_with_fail($sformatf("** Error at %0t: read of %h gave %h, expected %h",
                                      $time, addr, cpu_rdata, ref_byte(addr)));
    assert (n_wb - wb0 == (vdirty ? 1 : 0))
      else stop_with_fail($sformatf("** Error at %0t: %0d write-backs for access to %h",
                                    $time, n_wb - wb0, addr));
    assert (n_fill - fill0 == (was_hit ? 0 : 1))
      else stop_with_fail($sformatf("** Error at %0t: %0d fills for access to %h",
                                    $time, n_fill - fill0, addr));
    assert (n_upgr - upgr0 == ((was_hit && we && st0 == cache_pkg::ST_S) ? 1 : 0))
      else stop_with_fail($sformatf("** Error at %0t: %0d upgrades for access to %h",
                                    $time, n_upgr - upgr0, addr));
    if (!was_hit)
    begin
      assert (last_fill_op == (we ? cache_pkg::OP_RDX : cache_pkg::OP_RD))
        else stop_with_fail($sformatf("** Error at %0t: fill of %h used op %0d",
                                      $time, addr, last_fill_op));
      m_tag[idx][v] = addr[15:8];
      m_state[idx][v] = last_shared ? cache_pkg::ST_S : cache_pkg::ST_E;
      m_rr[idx] = m_rr[idx] + 2'd1;
      w = v;
    end
    if (we)
    begin
      m_state[idx][w] = cache_pkg::ST_M;
      ref_bytes[addr] = wdata;
    end
    if (we && was_hit)
      exp_wr_hit = exp_wr_hit + 1'b1;
    else if (we)
      exp_wr_miss = exp_wr_miss + 1'b1;
    else if (was_hit)
      exp_rd_hit = exp_rd_hit + 1'b1;
    else
      exp_rd_miss = exp_rd_miss + 1'b1;
    @(posedge CLK);
    cpu_req <= 1'b0;
    do @(negedge CLK); while (cpu_ack);
  endtask

  task automatic snoop_access(input logic rdx, input logic [15:0] addr);
    logic [3:0] idx;
    logic dirty;
    int w, cycles;
    idx = addr[7:4];
    w = find_way(idx, addr[15:8]);
    dirty = (w >= 0) && (m_state[idx][w] == cache_pkg::ST_M);
    @(posedge CLK);
    snoop_rdx  <= rdx;
    snoop_addr <= addr;
    snoop_req  <= 1'b1;
    cycles = 0;
    do
    begin
      @(negedge CLK);
      cycles++;
    end
    while (!snoop_ack);
    assert (cycles == 4)
      else stop_with_fail($sformatf("** Error at %0t: snoop of %h acked %0d cycles after req",
                                    $time, addr, cycles));
    assert (snoop_hit == (w >= 0) && snoop_dirty == dirty)
      else stop_with_fail($sformatf("** Error at %0t: snoop of %h hit %b dirty %b, expected %b %b",
                                    $time, addr, snoop_hit, snoop_dirty, w >= 0, dirty));
    if (dirty)
    begin
      assert (snoop_data == model_line(addr))
        else stop_with_fail($sformatf("** Error at %0t: snoop data for %h is %h, expected %h",
                                      $time, addr, snoop_data, model_line(addr)));
      mem_lines[{addr[15:4], 4'h0}] = model_line(addr);  // supplied dirty line reaches memory
    end
    if (w >= 0)
      m_state[idx][w] = rdx ? cache_pkg::ST_I : cache_pkg::ST_S;
    @(posedge CLK);
    snoop_req <= 1'b0;
    do @(negedge CLK); while (snoop_ack);
  endtask

  task automatic check_counter(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got == exp)
      else stop_with_fail($sformatf("** Error at %0t: %s counter is %0d, expected %0d",
                                    $time, name, got, exp));
  endtask

  // next level memory answering after 0 to 3 idle cycles
  initial
  begin : next_level
    logic [15:0] la;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    mem_shared = 1'b0;
    forever
    begin
      @(negedge CLK);
      if (mem_req && !mem_ack)
      begin
        la = mem_addr;
        // only a write back carries another tag than the processor's line
        assert (la[7:0] == {cpu_addr[7:4], 4'h0} &&
                (mem_op == cache_pkg::OP_WB || la[15:8] == cpu_addr[15:8]))
          else stop_with_fail($sformatf("** Error at %0t: bus op %0d on %h during access to %h",
                                        $time, mem_op, la, cpu_addr));
        case (mem_op)
          cache_pkg::OP_WB:
          begin
            check_writeback(la, mem_wdata);
            mem_lines[la] = mem_wdata;
            n_wb++;
          end
          cache_pkg::OP_UPGR: n_upgr++;
          default:
          begin
            n_fill++;
            last_fill_op = mem_op;
          end
        endcase
        repeat ($urandom_range(3, 0)) @(posedge CLK);
        @(posedge CLK);
        last_shared = ($urandom_range(1, 0) == 1);
        mem_shared <= last_shared;
        mem_rdata  <= mem_line(la);
        mem_ack    <= 1'b1;
        do @(negedge CLK); while (mem_req);
        @(posedge CLK);
        mem_ack <= 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    repeat (N_TXN * CYC_PER_TXN) @(posedge CLK);
    stop_with_fail($sformatf("timeout, %0d transactions did not finish within %0d cycles",
                             N_TXN, N_TXN * CYC_PER_TXN));
  end

  initial
  begin : stimulus
    logic [15:0] addr;
    void'($urandom(SEED));
    cpu_req    = 1'b0;
    cpu_we     = 1'b0;
    cpu_addr   = '0;
    cpu_wdata  = '0;
    snoop_req  = 1'b0;
    snoop_rdx  = 1'b0;
    snoop_addr = '0;
    exp_rd_hit  = '0;
    exp_rd_miss = '0;
    exp_wr_hit  = '0;
    exp_wr_miss = '0;
    for (int s = 0; s < cache_pkg::NUM_SETS; s++)
    begin
      m_rr[s] = '0;
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
      begin
        m_state[s][w] = cache_pkg::ST_I;
        m_tag[s][w]   = '0;
      end
    end
    while (RST !== 1'b1) @(negedge CLK);
    @(negedge CLK);
    check_counter("read hit", rd_hit_cnt, '0);
    check_counter("read miss", rd_miss_cnt, '0);
    check_counter("write hit", wr_hit_cnt, '0);
    check_counter("write miss", wr_miss_cnt, '0);
    for (int n = 0; n < N_TXN; n++)
    begin
      addr = pick_addr();
      if ($urandom_range(5, 0) == 0)
        snoop_access(($urandom_range(1, 0) == 1), addr);
      else
        cpu_access(($urandom_range(9, 0) < 4), addr, 8'($urandom));
    end
    check_counter("read hit", rd_hit_cnt, exp_rd_hit);
    check_counter("read miss", rd_miss_cnt, exp_rd_miss);
    check_counter("write hit", wr_hit_cnt, exp_wr_hit);
    check_counter("write miss", wr_miss_cnt, exp_wr_miss);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* l1_snoop_cache.f */
rtl/cache_pkg.sv
rtl/cache_way.sv
rtl/way_select.sv
rtl/cache_ctrl.sv
rtl/l1_snoop_cache.sv
dv/tb_clock.sv
dv/tb_l1_snoop_cache.sv

/* rtl/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
// cache controller: serves processor and snoop requests, keeps MESI states, drives the next level
module cache_ctrl (
  input  wire logic                              CLK,
  input  wire logic                              RST,
  input  wire logic                              cpu_req,
  input  wire logic                              cpu_we,
  input  wire logic [cache_pkg::ADDR_W-1:0]      cpu_addr,
  input  wire logic [7:0]                        cpu_wdata,
  output logic                                   cpu_ack,
  output logic [7:0]                             cpu_rdata,
  output logic                                   mem_req,
  output cache_pkg::bus_op_e                     mem_op,
  output logic [cache_pkg::ADDR_W-1:0]           mem_addr,
  output logic [cache_pkg::LINE_W-1:0]           mem_wdata,
  input  wire logic                              mem_ack,
  input  wire logic [cache_pkg::LINE_W-1:0]      mem_rdata,
  input  wire logic                              mem_shared,
  input  wire logic                              snoop_req,
  input  wire logic                              snoop_rdx,
  input  wire logic [cache_pkg::ADDR_W-1:0]      snoop_addr,
  output logic                                   snoop_ack,
  output logic                                   snoop_hit,
  output logic                                   snoop_dirty,
  output logic [cache_pkg::LINE_W-1:0]           snoop_data,
  input  wire logic                              hit,
  input  wire logic [cache_pkg::WAY_W-1:0]       hit_way,
  input  wire cache_pkg::mesi_e                  hit_state,
  input  wire logic [cache_pkg::LINE_W-1:0]      hit_line,
  input  wire logic [7:0]                        rd_byte,
  input  wire logic [cache_pkg::WAY_W-1:0]       victim_way,
  input  wire cache_pkg::mesi_e                  victim_state,
  input  wire logic [cache_pkg::TAG_W-1:0]       victim_tag,
  input  wire logic [cache_pkg::LINE_W-1:0]      victim_line,
  output logic [cache_pkg::INDEX_W-1:0]          index,
  output logic [cache_pkg::TAG_W-1:0]            lookup_tag,
  output logic [cache_pkg::OFFSET_W-1:0]         offset,
  output logic [cache_pkg::WAY_W-1:0]            rr_way,
  output logic [cache_pkg::TAG_W-1:0]            tag_wdata,
  output logic [cache_pkg::LINE_W-1:0]           line_wdata,
  output logic [7:0]                             byte_wdata,
  output cache_pkg::mesi_e                       state_wdata,
  output logic [cache_pkg::NUM_WAYS-1:0]         line_we,
  output logic [cache_pkg::NUM_WAYS-1:0]         byte_we,
  output logic [cache_pkg::NUM_WAYS-1:0]         state_we,
  output logic [cache_pkg::CNT_W-1:0]            rd_hit_cnt,
  output logic [cache_pkg::CNT_W-1:0]            rd_miss_cnt,
  output logic [cache_pkg::CNT_W-1:0]            wr_hit_cnt,
  output logic [cache_pkg::CNT_W-1:0]            wr_miss_cnt
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_UPDATE,
    S_WB,
    S_FILL,
    S_UPGR,
    S_ACK
  } ctrl_state_e;

  ctrl_state_e              st;
  logic                     snp;     // current request came from the snoop channel
  logic                     miss_r;  // first lookup of this access missed
  logic [cache_pkg::WAY_W-1:0] rr_ptr [cache_pkg::NUM_SETS];
  cache_pkg::cache_addr_u   cur_a;
  cache_pkg::cache_addr_u   mem_a;
  logic                     bus_done;
  logic                     fill_done;

  // requester holds its address stable until ack, so no copy is kept
  always_comb
  begin
    cur_a.raw = snp ? snoop_addr : cpu_addr;
  end

  assign index      = cur_a.f.index;
  assign lookup_tag = cur_a.f.tag;
  assign offset     = cur_a.f.offset;
  assign rr_way     = rr_ptr[cur_a.f.index];

  assign bus_done  = mem_req && mem_ack;
  assign fill_done = (st == S_FILL) && bus_done;

  // line address on the bus, victim tag during write back
  always_comb
  begin
    mem_a.f.tag    = (st == S_WB) ? victim_tag : cur_a.f.tag;
    mem_a.f.index  = cur_a.f.index;
    mem_a.f.offset = '0;
  end

  assign mem_addr  = mem_a.raw;
  assign mem_wdata = victim_line;

  always_comb
  begin
    case (st)
      S_WB:    mem_op = cache_pkg::OP_WB;
      S_UPGR:  mem_op = cache_pkg::OP_UPGR;
      default: mem_op = cpu_we ? cache_pkg::OP_RDX : cache_pkg::OP_RD;
    endcase
  end

  assign tag_wdata  = cur_a.f.tag;
  assign line_wdata = mem_rdata;
  assign byte_wdata = cpu_wdata;

  // way write strobes, fills go to the victim, updates to the hit way
  always_comb
  begin
    line_we     = '0;
    byte_we     = '0;
    state_we    = '0;
    state_wdata = cache_pkg::ST_I;
    if (fill_done)
    begin
      line_we[victim_way]  = 1'b1;
      state_we[victim_way] = 1'b1;
      // a write fill is exclusive, the update that follows makes it M
      state_wdata = (cpu_we || !mem_shared) ? cache_pkg::ST_E : cache_pkg::ST_S;
    end
    else if (st == S_UPDATE && hit)
    begin
      if (snp)
      begin
        state_we[hit_way] = 1'b1;
        state_wdata = snoop_rdx ? cache_pkg::ST_I : cache_pkg::ST_S;
      end
      else if (cpu_we)
      begin
        byte_we[hit_way]  = 1'b1;
        state_we[hit_way] = 1'b1;
        state_wdata = cache_pkg::ST_M;
      end
    end
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      st          <= S_IDLE;
      snp         <= 1'b0;
      miss_r      <= 1'b0;
      cpu_ack     <= 1'b0;
      snoop_ack   <= 1'b0;
      snoop_hit   <= 1'b0;
      snoop_dirty <= 1'b0;
      mem_req     <= 1'b0;
      rd_hit_cnt  <= '0;
      rd_miss_cnt <= '0;
      wr_hit_cnt  <= '0;
      wr_miss_cnt <= '0;
      for (int s = 0; s < cache_pkg::NUM_SETS; s++)
      begin
        rr_ptr[s] <= '0;
      end
    end
    else
    begin
      case (st)
        S_IDLE:
        begin
          miss_r <= 1'b0;
          if (snoop_req)  // snoop wins a tie
          begin
            snp <= 1'b1;
            st  <= S_LOOKUP;
          end
          else if (cpu_req)
          begin
            snp <= 1'b0;
            st  <= S_LOOKUP;
          end
        end
        S_LOOKUP:
        begin
          if (snp || (hit && !(cpu_we && hit_state == cache_pkg::ST_S)))
            st <= S_UPDATE;
          else if (hit)
            st <= S_UPGR;  // write to a shared line
          else
          begin
            miss_r <= 1'b1;
            st     <= (victim_state == cache_pkg::ST_M) ? S_WB : S_FILL;
          end
        end
        S_UPDATE:
        begin
          st <= S_ACK;
          if (snp)
          begin
            snoop_ack   <= 1'b1;
            snoop_hit   <= hit;
            snoop_dirty <= hit && (hit_state == cache_pkg::ST_M);
          end
          else
          begin
            cpu_ack <= 1'b1;
            // each access is counted once, when it is acknowledged
            if (cpu_we && miss_r)
              wr_miss_cnt <= wr_miss_cnt + 1'b1;
            else if (cpu_we)
              wr_hit_cnt <= wr_hit_cnt + 1'b1;
            else if (miss_r)
              rd_miss_cnt <= rd_miss_cnt + 1'b1;
            else
              rd_hit_cnt <= rd_hit_cnt + 1'b1;
          end
        end
        S_WB, S_FILL, S_UPGR:
        begin
          if (bus_done)
          begin
            mem_req <= 1'b0;
            if (st == S_WB)
              st <= S_FILL;
            else if (st == S_FILL)
            begin
              rr_ptr[cur_a.f.index] <= rr_ptr[cur_a.f.index] + 1'b1;
              st <= S_LOOKUP;  // look again, the filled line now hits
            end
            else
              st <= S_UPDATE;
          end
          else if (!mem_req && !mem_ack)
            mem_req <= 1'b1;  // previous bus ack must be gone first
        end
        S_ACK:
        begin
          if (snp && !snoop_req)
          begin
            snoop_ack <= 1'b0;
            st        <= S_IDLE;
          end
          else if (!snp && !cpu_req)
          begin
            cpu_ack <= 1'b0;
            st      <= S_IDLE;
          end
        end
        default: st <= S_IDLE;
      endcase
    end
  end

  // returned data, valid while the matching ack is high
  always_ff @(posedge CLK)
  begin
    if (st == S_UPDATE)
    begin
      cpu_rdata  <= rd_byte;
      snoop_data <= hit_line;
    end
  end

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none
// cache package: geometry, MESI encoding, bus opcodes and the address view of the L1 cache
package cache_pkg;

  // address split is tag | index | offset
  localparam int ADDR_W     = 16;
  localparam int OFFSET_W   = 4;
  localparam int INDEX_W    = 4;
  localparam int TAG_W      = 8;

  localparam int NUM_WAYS   = 4;
  localparam int WAY_W      = 2;
  localparam int NUM_SETS   = 16;
  localparam int LINE_BYTES = 16;
  localparam int LINE_W     = LINE_BYTES * 8;  // 128 bit line

  localparam int CNT_W      = 16;  // event counter width

  // line state, invalid is all zero so a cleared array reads as empty
  typedef enum logic [1:0] {
    ST_I = 2'b00,
    ST_S = 2'b01,
    ST_E = 2'b10,
    ST_M = 2'b11
  } mesi_e;

  // next level operations
  typedef enum logic [1:0] {
    OP_RD   = 2'b00,  // read, line may be shared
    OP_RDX  = 2'b01,  // read for ownership
    OP_UPGR = 2'b10,  // claim ownership of a shared line, no data
    OP_WB   = 2'b11   // write back a modified line
  } bus_op_e;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } addr_fields_t;

  // the same word seen as a flat byte address or as its fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    addr_fields_t      f;
  } cache_addr_u;

endpackage

`default_nettype wire

/* rtl/cache_way.sv */
`timescale 1ns/1ps
`default_nettype none
// cache way: tag, MESI state and data line storage of one way for every set
module cache_way (
  input  wire logic                                CLK,
  input  wire logic                                RST,
  input  wire logic [cache_pkg::INDEX_W-1:0]      index,
  input  wire logic [cache_pkg::OFFSET_W-1:0]     wr_byte_sel,
  input  wire logic [cache_pkg::TAG_W-1:0]        tag_wdata,
  input  wire logic [cache_pkg::LINE_W-1:0]       line_wdata,
  input  wire logic [7:0]                          byte_wdata,
  input  wire cache_pkg::mesi_e                    state_wdata,
  input  wire logic                                line_we,
  input  wire logic                                byte_we,
  input  wire logic                                state_we,
  output logic [cache_pkg::TAG_W-1:0]              tag,
  output cache_pkg::mesi_e                         state,
  output logic [cache_pkg::LINE_W-1:0]             line
);

  logic [cache_pkg::TAG_W-1:0]  tag_mem   [cache_pkg::NUM_SETS];
  logic [cache_pkg::LINE_W-1:0] line_mem  [cache_pkg::NUM_SETS];
  cache_pkg::mesi_e             state_mem [cache_pkg::NUM_SETS];

  // every line starts invalid
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      for (int s = 0; s < cache_pkg::NUM_SETS; s++)
      begin
        state_mem[s] <= cache_pkg::ST_I;
      end
    end
    else if (state_we)
    begin
      state_mem[index] <= state_wdata;
    end
  end

  // a fill replaces tag and whole line, a processor write patches one byte
  always_ff @(posedge CLK)
  begin
    if (line_we)
    begin
      tag_mem[index]  <= tag_wdata;
      line_mem[index] <= line_wdata;
    end
    else if (byte_we)
    begin
      line_mem[index][wr_byte_sel*8 +: 8] <= byte_wdata;
    end
  end

  assign tag   = tag_mem[index];
  assign state = state_mem[index];
  assign line  = line_mem[index];

endmodule

`default_nettype wire

/* rtl/l1_snoop_cache.sv */
`timescale 1ns/1ps
`default_nettype none
// L1 snooping data cache: controller, four storage ways and the way selector
module l1_snoop_cache (
  input  wire logic                              CLK,
  input  wire logic                              RST,
  input  wire logic                              cpu_req,
  input  wire logic                              cpu_we,
  input  wire logic [cache_pkg::ADDR_W-1:0]      cpu_addr,
  input  wire logic [7:0]                        cpu_wdata,
  output wire logic                              cpu_ack,
  output wire logic [7:0]                        cpu_rdata,
  output wire logic                              mem_req,
  output wire cache_pkg::bus_op_e                mem_op,
  output wire logic [cache_pkg::ADDR_W-1:0]      mem_addr,
  output wire logic [cache_pkg::LINE_W-1:0]      mem_wdata,
  input  wire logic                              mem_ack,
  input  wire logic [cache_pkg::LINE_W-1:0]      mem_rdata,
  input  wire logic                              mem_shared,
  input  wire logic                              snoop_req,
  input  wire logic                              snoop_rdx,
  input  wire logic [cache_pkg::ADDR_W-1:0]      snoop_addr,
  output wire logic                              snoop_ack,
  output wire logic                              snoop_hit,
  output wire logic                              snoop_dirty,
  output wire logic [cache_pkg::LINE_W-1:0]      snoop_data,
  output wire logic [cache_pkg::CNT_W-1:0]       rd_hit_cnt,
  output wire logic [cache_pkg::CNT_W-1:0]       rd_miss_cnt,
  output wire logic [cache_pkg::CNT_W-1:0]       wr_hit_cnt,
  output wire logic [cache_pkg::CNT_W-1:0]       wr_miss_cnt
);

  localparam int NW = cache_pkg::NUM_WAYS;

  // controller to ways
  wire logic [cache_pkg::INDEX_W-1:0]  index;
  wire logic [cache_pkg::OFFSET_W-1:0] offset;
  wire logic [cache_pkg::TAG_W-1:0]    tag_wdata;
  wire logic [cache_pkg::LINE_W-1:0]   line_wdata;
  wire logic [7:0]                     byte_wdata;
  wire cache_pkg::mesi_e               state_wdata;
  wire logic [NW-1:0]                  line_we;
  wire logic [NW-1:0]                  byte_we;
  wire logic [NW-1:0]                  state_we;

  // ways to selector, flattened with way 0 in the low bits
  wire logic [NW*cache_pkg::TAG_W-1:0]  way_tags;
  wire logic [NW*2-1:0]                 way_states;
  wire logic [NW*cache_pkg::LINE_W-1:0] way_lines;

  // selector back to controller
  wire logic [cache_pkg::TAG_W-1:0]  lookup_tag;
  wire logic [cache_pkg::WAY_W-1:0]  rr_way;
  wire logic                         hit;
  wire logic [cache_pkg::WAY_W-1:0]  hit_way;
  wire cache_pkg::mesi_e             hit_state;
  wire logic [cache_pkg::LINE_W-1:0] hit_line;
  wire logic [7:0]                   rd_byte;
  wire logic [cache_pkg::WAY_W-1:0]  victim_way;
  wire cache_pkg::mesi_e             victim_state;
  wire logic [cache_pkg::TAG_W-1:0]  victim_tag;
  wire logic [cache_pkg::LINE_W-1:0] victim_line;

  cache_ctrl u_ctrl (
    .CLK, .RST,
    .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_ack, .cpu_rdata,
    .mem_req, .mem_op, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata, .mem_shared,
    .snoop_req, .snoop_rdx, .snoop_addr, .snoop_ack, .snoop_hit, .snoop_dirty, .snoop_data,
    .hit, .hit_way, .hit_state, .hit_line, .rd_byte,
    .victim_way, .victim_state, .victim_tag, .victim_line,
    .index, .lookup_tag, .offset, .rr_way,
    .tag_wdata, .line_wdata, .byte_wdata, .state_wdata,
    .line_we, .byte_we, .state_we,
    .rd_hit_cnt, .rd_miss_cnt, .wr_hit_cnt, .wr_miss_cnt
  );

  for (genvar g = 0; g < NW; g++)
  begin : g_way
    cache_way u_way (
      .CLK, .RST,
      .index,
      .wr_byte_sel (offset),
      .tag_wdata, .line_wdata, .byte_wdata, .state_wdata,
      .line_we     (line_we[g]),
      .byte_we     (byte_we[g]),
      .state_we    (state_we[g]),
      .tag         (way_tags[g*cache_pkg::TAG_W +: cache_pkg::TAG_W]),
      .state       (way_states[g*2 +: 2]),
      .line        (way_lines[g*cache_pkg::LINE_W +: cache_pkg::LINE_W])
    );
  end

  way_select u_sel (
    .way_tags, .way_states, .way_lines,
    .lookup_tag, .offset, .rr_way,
    .hit, .hit_way, .hit_state, .hit_line, .rd_byte,
    .victim_way, .victim_state, .victim_tag, .victim_line
  );

endmodule

`default_nettype wire

/* rtl/way_select.sv */
`timescale 1ns/1ps
`default_nettype none
// way selector: compares the four ways of a set, picks the hit byte and the victim way
module way_select (
  input  wire logic [cache_pkg::NUM_WAYS*cache_pkg::TAG_W-1:0]   way_tags,
  input  wire logic [cache_pkg::NUM_WAYS*2-1:0]                  way_states,
  input  wire logic [cache_pkg::NUM_WAYS*cache_pkg::LINE_W-1:0]  way_lines,
  input  wire logic [cache_pkg::TAG_W-1:0]                       lookup_tag,
  input  wire logic [cache_pkg::OFFSET_W-1:0]                    offset,
  input  wire logic [cache_pkg::WAY_W-1:0]                       rr_way,
  output logic                                                    hit,
  output logic [cache_pkg::WAY_W-1:0]                             hit_way,
  output cache_pkg::mesi_e                                        hit_state,
  output logic [cache_pkg::LINE_W-1:0]                            hit_line,
  output logic [7:0]                                              rd_byte,
  output logic [cache_pkg::WAY_W-1:0]                             victim_way,
  output cache_pkg::mesi_e                                        victim_state,
  output logic [cache_pkg::TAG_W-1:0]                             victim_tag,
  output logic [cache_pkg::LINE_W-1:0]                            victim_line
);

  localparam int TW = cache_pkg::TAG_W;
  localparam int LW = cache_pkg::LINE_W;

  // walk from the top way down so the lowest matching way wins
  always_comb
  begin
    hit        = 1'b0;
    hit_way    = '0;
    victim_way = rr_way;  // all ways valid, fall back to round robin
    for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--)
    begin
      if (way_states[w*2 +: 2] == cache_pkg::ST_I)
      begin
        victim_way = cache_pkg::WAY_W'(w);
      end
      else if (way_tags[w*TW +: TW] == lookup_tag)
      begin
        hit     = 1'b1;
        hit_way = cache_pkg::WAY_W'(w);
      end
    end
  end

  assign hit_state = cache_pkg::mesi_e'(way_states[hit_way*2 +: 2]);
  assign hit_line  = way_lines[hit_way*LW +: LW];
  assign rd_byte   = hit_line[offset*8 +: 8];

  // victim fields feed the write back
  assign victim_state = cache_pkg::mesi_e'(way_states[victim_way*2 +: 2]);
  assign victim_tag   = way_tags[victim_way*TW +: TW];
  assign victim_line  = way_lines[victim_way*LW +: LW];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the L1 snoop cache testbench with Verilator and run it, exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_l1_snoop_cache \
  -f l1_snoop_cache.f -o tb_l1_snoop_cache &&
./obj_dir/tb_l1_snoop_cache || exit 1
